// ==== hdl/io_switch_pkg.sv ====
//################################################
// shared widths and timeouts for the IO switch
// two downstream clients, counters sized from the
// timeout values
//################################################

package io_switch_pkg;

	localparam int PHYS_BITS = 56;
	localparam int XLEN = 64;
	localparam int NIOCLIENTS = 2;

	// waiting cycles before the watchdog steps in
	localparam int ADDR_TIMEOUT = 16;
	localparam int DATA_TIMEOUT = 4095;

	typedef logic [PHYS_BITS-1:0] phys_addr_t;
	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [XLEN/8-1:0] byte_mask_t;
	typedef logic [NIOCLIENTS-1:0] client_vec_t;

	typedef logic [$clog2(ADDR_TIMEOUT+1)-1:0] addr_cnt_t;
	typedef logic [$clog2(DATA_TIMEOUT+1)-1:0] data_cnt_t;

	typedef enum logic {
		arb_idle,
		arb_read	// waiting on the data phase of a granted read
	} arb_state_t;

endpackage

// ==== hdl/io_arbiter.sv ====
//################################################
// round-robin arbiter for two CPUs on one IO bus
// a locked CPU keeps the other one out until it
// makes an unlocked access; one read in flight
//################################################
`timescale 1ns/10ps

module io_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     cpu_addr_req_0,
	input  io_switch_pkg::phys_addr_t cpu_addr_0,
	input  logic                     cpu_read_0,
	input  logic                     cpu_lock_0,
	input  io_switch_pkg::byte_mask_t cpu_mask_0,
	input  io_switch_pkg::xlen_t      cpu_wdata_0,
	input  logic                     cpu_data_ack_0,

	input  logic                     cpu_addr_req_1,
	input  io_switch_pkg::phys_addr_t cpu_addr_1,
	input  logic                     cpu_read_1,
	input  logic                     cpu_lock_1,
	input  io_switch_pkg::byte_mask_t cpu_mask_1,
	input  io_switch_pkg::xlen_t      cpu_wdata_1,
	input  logic                     cpu_data_ack_1,

	input  io_switch_pkg::client_vec_t io_addr_ack,
	input  io_switch_pkg::client_vec_t io_data_req,
	input  io_switch_pkg::client_vec_t io_data_err,
	input  io_switch_pkg::xlen_t      io_rdata,
	input  logic                     force_addr_ack,
	input  logic                     force_data_req,

	output logic                     cpu_addr_ack_0,
	output logic                     cpu_addr_ack_1,
	output logic                     cpu_data_req_0,
	output logic                     cpu_data_req_1,
	output io_switch_pkg::xlen_t      cpu_rdata,
	output logic                     cpu_data_err,

	output logic                     io_addr_req,
	output io_switch_pkg::phys_addr_t io_addr,
	output logic                     io_read,
	output io_switch_pkg::byte_mask_t io_mask,
	output io_switch_pkg::xlen_t      io_wdata,
	output logic                     io_data_ack,
	output logic                     read_active
);
	import io_switch_pkg::*;

	arb_state_t state_q;
	logic       rr_q;		// high favours cpu 1
	logic       owner_q;
	logic [1:0] lock_q;

	logic elig_0;
	logic elig_1;
	logic sel_1;
	logic addr_ack;
	logic grant;
	logic sel_lock;
	logic data_valid;

	// a CPU is shut out while the other holds its lock
	assign elig_0 = cpu_addr_req_0 && !lock_q[1];
	assign elig_1 = cpu_addr_req_1 && !lock_q[0];
	assign sel_1 = elig_1 && (!elig_0 || rr_q);

	assign read_active = (state_q == arb_read);
	assign io_addr_req = !read_active && (elig_0 || elig_1);

	assign io_addr = sel_1 ? cpu_addr_1 : cpu_addr_0;
	assign io_read = sel_1 ? cpu_read_1 : cpu_read_0;
	assign io_mask = sel_1 ? cpu_mask_1 : cpu_mask_0;
	assign io_wdata = sel_1 ? cpu_wdata_1 : cpu_wdata_0;
	assign sel_lock = sel_1 ? cpu_lock_1 : cpu_lock_0;

	assign addr_ack = (|io_addr_ack) || force_addr_ack;
	assign grant = io_addr_req && addr_ack;
	assign cpu_addr_ack_0 = grant && !sel_1;
	assign cpu_addr_ack_1 = grant && sel_1;

	// data phase goes only to the owner of the read
	assign data_valid = (|io_data_req) || force_data_req;
	assign cpu_data_req_0 = read_active && !owner_q && data_valid;
	assign cpu_data_req_1 = read_active && owner_q && data_valid;
	assign io_data_ack = (cpu_data_req_0 && cpu_data_ack_0) ||
		(cpu_data_req_1 && cpu_data_ack_1);

	assign cpu_rdata = io_rdata;
	assign cpu_data_err = (|(io_data_req & io_data_err)) || force_data_req;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= arb_idle;
			rr_q <= 1'b0;
			owner_q <= 1'b0;
			lock_q <= 2'b00;
		end else begin
			if (grant) begin
				rr_q <= !sel_1;		// other CPU goes next
				lock_q[sel_1] <= sel_lock;
				if (io_read) begin
					state_q <= arb_read;
					owner_q <= sel_1;
				end
			end else if (io_data_ack) begin
				state_q <= arb_idle;
			end
		end
	end

endmodule

// ==== hdl/io_bus_watchdog.sv ====
//################################################
// bus watchdog, forces an address ack after
// ADDR_TIMEOUT unanswered cycles and an error
// response when read data never shows up
//################################################
`timescale 1ns/10ps

module io_bus_watchdog (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      io_addr_req,
	input  logic                      io_read,
	input  io_switch_pkg::client_vec_t io_addr_ack,
	input  io_switch_pkg::client_vec_t io_data_req,
	input  logic                      io_data_ack,
	input  logic                      read_active,
	output logic                      force_addr_ack,
	output logic                      force_data_req
);
	import io_switch_pkg::*;

	addr_cnt_t addr_cnt;
	data_cnt_t data_cnt;
	logic      force_q;		// forced response pending
	logic      addr_wait;
	logic      data_wait;
	logic      data_expired;

	assign addr_wait = io_addr_req && !(|io_addr_ack);
	assign force_addr_ack = addr_wait && (addr_cnt == addr_cnt_t'(ADDR_TIMEOUT - 1));

	// no count while a forced response is already pending
	assign data_wait = read_active && !(|io_data_req) && !force_q;
	assign data_expired = data_wait && (data_cnt == data_cnt_t'(DATA_TIMEOUT - 1));

	assign force_data_req = force_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			addr_cnt <= '0;
		end else if (!addr_wait || force_addr_ack) begin
			addr_cnt <= '0;
		end else begin
			addr_cnt <= addr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_cnt <= '0;
		end else if (!read_active) begin
			data_cnt <= '0;
		end else if (data_wait) begin
			data_cnt <= data_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			force_q <= 1'b0;
		end else if (force_q) begin
			force_q <= !io_data_ack;	// held until the owner takes it
		end else if (force_addr_ack && io_read) begin
			force_q <= 1'b1;	// nobody decoded this read
		end else if (data_expired) begin
			force_q <= 1'b1;
		end
	end

endmodule

// ==== hdl/io_switch.sv ====
//################################################
// two-CPU IO switch onto one downstream bus
// address ack is combinational from the clients;
// both CPUs see the same read data and error
//################################################
`timescale 1ns/10ps

module io_switch (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      cpu_addr_req_0,
	output logic                      cpu_addr_ack_0,
	input  io_switch_pkg::phys_addr_t  cpu_addr_0,
	input  logic                      cpu_read_0,
	input  logic                      cpu_lock_0,
	input  io_switch_pkg::byte_mask_t  cpu_mask_0,
	input  io_switch_pkg::xlen_t       cpu_wdata_0,
	output logic                      cpu_data_req_0,
	input  logic                      cpu_data_ack_0,
	output io_switch_pkg::xlen_t       cpu_rdata_0,
	output logic                      cpu_data_err_0,

	input  logic                      cpu_addr_req_1,
	output logic                      cpu_addr_ack_1,
	input  io_switch_pkg::phys_addr_t  cpu_addr_1,
	input  logic                      cpu_read_1,
	input  logic                      cpu_lock_1,
	input  io_switch_pkg::byte_mask_t  cpu_mask_1,
	input  io_switch_pkg::xlen_t       cpu_wdata_1,
	output logic                      cpu_data_req_1,
	input  logic                      cpu_data_ack_1,
	output io_switch_pkg::xlen_t       cpu_rdata_1,
	output logic                      cpu_data_err_1,

	output logic                      io_addr_req,
	input  io_switch_pkg::client_vec_t io_addr_ack,
	output io_switch_pkg::phys_addr_t  io_addr,
	output logic                      io_read,
	output io_switch_pkg::byte_mask_t  io_mask,
	output io_switch_pkg::xlen_t       io_wdata,
	input  io_switch_pkg::client_vec_t io_data_req,
	output logic                      io_data_ack,
	input  io_switch_pkg::xlen_t       io_rdata,
	input  io_switch_pkg::client_vec_t io_data_err
);
	import io_switch_pkg::*;

	logic  force_addr_ack;
	logic  force_data_req;
	logic  read_active;
	xlen_t cpu_rdata;
	logic  cpu_data_err;

	// shared return path
	assign cpu_rdata_0 = cpu_rdata;
	assign cpu_rdata_1 = cpu_rdata;
	assign cpu_data_err_0 = cpu_data_err;
	assign cpu_data_err_1 = cpu_data_err;

	io_arbiter arb_i (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_addr_req_0(cpu_addr_req_0),
		.cpu_addr_0(cpu_addr_0),
		.cpu_read_0(cpu_read_0),
		.cpu_lock_0(cpu_lock_0),
		.cpu_mask_0(cpu_mask_0),
		.cpu_wdata_0(cpu_wdata_0),
		.cpu_data_ack_0(cpu_data_ack_0),
		.cpu_addr_req_1(cpu_addr_req_1),
		.cpu_addr_1(cpu_addr_1),
		.cpu_read_1(cpu_read_1),
		.cpu_lock_1(cpu_lock_1),
		.cpu_mask_1(cpu_mask_1),
		.cpu_wdata_1(cpu_wdata_1),
		.cpu_data_ack_1(cpu_data_ack_1),
		.io_addr_ack(io_addr_ack),
		.io_data_req(io_data_req),
		.io_data_err(io_data_err),
		.io_rdata(io_rdata),
		.force_addr_ack(force_addr_ack),
		.force_data_req(force_data_req),
		.cpu_addr_ack_0(cpu_addr_ack_0),
		.cpu_addr_ack_1(cpu_addr_ack_1),
		.cpu_data_req_0(cpu_data_req_0),
		.cpu_data_req_1(cpu_data_req_1),
		.cpu_rdata(cpu_rdata),
		.cpu_data_err(cpu_data_err),
		.io_addr_req(io_addr_req),
		.io_addr(io_addr),
		.io_read(io_read),
		.io_mask(io_mask),
		.io_wdata(io_wdata),
		.io_data_ack(io_data_ack),
		.read_active(read_active)
	);

	io_bus_watchdog wdog_i (
		.clk(clk),
		.rst_n(rst_n),
		.io_addr_req(io_addr_req),
		.io_read(io_read),
		.io_addr_ack(io_addr_ack),
		.io_data_req(io_data_req),
		.io_data_ack(io_data_ack),
		.read_active(read_active),
		.force_addr_ack(force_addr_ack),
		.force_data_req(force_data_req)
	);

endmodule

// ==== bench/io_switch_chk.sv ====
//################################################
// protocol assertions bound into io_switch
//################################################
`timescale 1ns/10ps

module io_switch_chk (
	input logic clk,
	input logic rst_n,
	input logic cpu_addr_ack_0,
	input logic cpu_addr_ack_1,
	input logic cpu_data_req_0,
	input logic cpu_data_req_1,
	input logic io_data_ack
);

	int fails = 0;	// failed assertion count

	addr_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_addr_ack_0 && cpu_addr_ack_1))
		else begin
			$error("address acknowledge sent to both CPUs");
			fails++;
		end

	data_req_single: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_data_req_0 && cpu_data_req_1))
		else begin
			$error("data request raised to both CPUs");
			fails++;
		end

	// bus ack only while an owner sees data
	data_ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
		io_data_ack |-> (cpu_data_req_0 || cpu_data_req_1))
		else begin
			$error("io_data_ack without a CPU data request");
			fails++;
		end

endmodule

bind io_switch io_switch_chk chk_i (
	.clk(clk),
	.rst_n(rst_n),
	.cpu_addr_ack_0(cpu_addr_ack_0),
	.cpu_addr_ack_1(cpu_addr_ack_1),
	.cpu_data_req_0(cpu_data_req_0),
	.cpu_data_req_1(cpu_data_req_1),
	.io_data_ack(io_data_ack)
);

// ==== bench/io_switch_tests.svh ====
//################################################
// directed tests included into the testbench body
// each test starts from its own reset
//################################################

	task automatic request(input bit cpu, input phys_addr_t addr, input logic rd,
			input logic lock, input byte_mask_t mask, input xlen_t data);
		if (cpu)
			{cpu_addr_req_1, cpu_addr_1, cpu_read_1, cpu_lock_1, cpu_mask_1, cpu_wdata_1} =
				{1'b1, addr, rd, lock, mask, data};
		else
			{cpu_addr_req_0, cpu_addr_0, cpu_read_0, cpu_lock_0, cpu_mask_0, cpu_wdata_0} =
				{1'b1, addr, rd, lock, mask, data};
	endtask

	task automatic drop(input bit cpu);
		if (cpu)
			cpu_addr_req_1 = 1'b0;
		else
			cpu_addr_req_0 = 1'b0;
	endtask

	function automatic phys_addr_t rand_addr();
		return phys_addr_t'({xorshift(), xorshift()});
	endfunction

	function automatic xlen_t rand_data();
		return {xorshift(), xorshift()};
	endfunction

	task automatic forward_write();
		xlen_t data;
		byte_mask_t mask;
		data = rand_data();
		mask = byte_mask_t'(xorshift());
		reset_dut();
		request(1'b1, rand_addr(), 1'b0, 1'b0, mask, data);
		@(negedge clk);
		check_bit("io_addr_req", 1'b1, io_addr_req);
		check_mask("io_mask", mask, io_mask);
		check_data("io_wdata", data, io_wdata);
		check_bit("io_read", 1'b0, io_read);
		next_cycle();
		grant_by_client(1'b1, xorshift() % 4);
		drop(1'b1);
		io_data_req = '1;	// stray data request with no read open
		repeat (3) begin	// no data phase for a write
			@(negedge clk);
			check_bit("io_addr_req", 1'b0, io_addr_req);
			check_bit("cpu_data_req_1", 1'b0, cpu_data_req_1);
			next_cycle();
		end
		io_data_req = '0;
	endtask

	task automatic read_return();
		reset_dut();
		request(1'b0, rand_addr(), 1'b1, 1'b0, '1, '0);
		grant_by_client(1'b0, xorshift() % 4);
		drop(1'b0);
		repeat (xorshift() % 4) begin
			@(negedge clk);
			check_bit("cpu_data_req_0", 1'b0, cpu_data_req_0);
			next_cycle();
		end
		return_data(1'b0, rand_data(), 1'b0);
		take_data(1'b0);
	endtask

	task automatic alternate_grants();
		reset_dut();
		request(1'b0, rand_addr(), 1'b0, 1'b0, '1, rand_data());
		request(1'b1, rand_addr(), 1'b0, 1'b0, '1, rand_data());
		for (int i = 0; i < 6; i++)
			grant_by_client(i[0], xorshift() % 3);	// cpu 0 first after reset
		drop(1'b0);
		drop(1'b1);
	endtask

	task automatic lock_blocks_other();
		reset_dut();
		request(1'b0, rand_addr(), 1'b1, 1'b1, '1, '0);
		grant_by_client(1'b0, 0);
		drop(1'b0);
		return_data(1'b0, rand_data(), 1'b0);
		take_data(1'b0);
		next_cycle();
		// pointer favours cpu 1 now but the lock keeps it out
		request(1'b1, rand_addr(), 1'b0, 1'b0, '1, rand_data());
		request(1'b0, rand_addr(), 1'b0, 1'b1, '1, rand_data());
		grant_by_client(1'b0, xorshift() % 3);
		request(1'b0, rand_addr(), 1'b0, 1'b0, '1, rand_data());
		grant_by_client(1'b0, 0);	// unlocked write releases cpu 1
		drop(1'b0);
		grant_by_client(1'b1, 0);
		drop(1'b1);
	endtask

	task automatic unanswered_address();
		reset_dut();
		request(1'b0, rand_addr(), 1'b1, 1'b0, '1, '0);
		for (int i = 1; i <= ADDR_TIMEOUT; i++) begin
			@(negedge clk);
			check_bit("cpu_addr_ack_0", i == ADDR_TIMEOUT, cpu_addr_ack_0);
			check_bit("cpu_data_req_0", 1'b0, cpu_data_req_0);
			next_cycle();
		end
		drop(1'b0);
		@(negedge clk);
		check_bit("cpu_data_req_0", 1'b1, cpu_data_req_0);
		check_bit("cpu_data_err_0", 1'b1, cpu_data_err_0);
		next_cycle();
		take_data(1'b0);
		next_cycle();
		// client flags its own error
		request(1'b1, rand_addr(), 1'b1, 1'b0, '1, '0);
		grant_by_client(1'b1, 0);
		drop(1'b1);
		return_data(1'b1, rand_data(), 1'b1);
		take_data(1'b1);
	endtask

	task automatic missing_read_data();
		reset_dut();
		request(1'b1, rand_addr(), 1'b1, 1'b0, '1, '0);
		grant_by_client(1'b1, xorshift() % 4);
		drop(1'b1);
		repeat (DATA_TIMEOUT) begin	// first cycle in arb_read onwards
			@(negedge clk);
			check_bit("cpu_data_req_1", 1'b0, cpu_data_req_1);
			next_cycle();
		end
		@(negedge clk);
		check_bit("cpu_data_req_1", 1'b1, cpu_data_req_1);
		check_bit("cpu_data_err_1", 1'b1, cpu_data_err_1);
		next_cycle();
		take_data(1'b1);
	endtask

// ==== bench/io_switch_tb.sv ====
//################################################
// directed tests with a simple bus client model
// inputs change 1 ns after the rising edge and
// outputs are sampled at the falling edge
//################################################
`timescale 1ns/10ps

module io_switch_tb;
	import io_switch_pkg::*;

	logic clk, rst_n;
	logic cpu_addr_req_0, cpu_addr_ack_0, cpu_read_0, cpu_lock_0;
	logic cpu_data_req_0, cpu_data_ack_0, cpu_data_err_0;
	logic cpu_addr_req_1, cpu_addr_ack_1, cpu_read_1, cpu_lock_1;
	logic cpu_data_req_1, cpu_data_ack_1, cpu_data_err_1;
	phys_addr_t cpu_addr_0, cpu_addr_1, io_addr;
	byte_mask_t cpu_mask_0, cpu_mask_1, io_mask;
	xlen_t cpu_wdata_0, cpu_wdata_1, cpu_rdata_0, cpu_rdata_1, io_wdata, io_rdata;
	logic io_addr_req, io_read, io_data_ack;
	client_vec_t io_addr_ack, io_data_req, io_data_err;

	int errors;
	logic [31:0] rng_state;

	io_switch io_switch_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = !clk;
	end

	// the data timeout test dominates the run time
	initial begin
		repeat (4 * DATA_TIMEOUT + 2000) @(posedge clk);
		$display("timeout, the tests did not complete");
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_inputs();
		{cpu_addr_req_0, cpu_read_0, cpu_lock_0, cpu_data_ack_0} = '0;
		{cpu_addr_req_1, cpu_read_1, cpu_lock_1, cpu_data_ack_1} = '0;
		{cpu_addr_0, cpu_addr_1, cpu_mask_0, cpu_mask_1, cpu_wdata_0, cpu_wdata_1} = '0;
		{io_addr_ack, io_data_req, io_data_err, io_rdata} = '0;
	endtask

	task automatic reset_dut();
		next_cycle();
		idle_inputs();
		rst_n = 1'b0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
	endtask

	task automatic check_addr(input string name, input phys_addr_t exp, input phys_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// one client answers the address after a delay
	task automatic grant_by_client(input bit cpu, input int delay);
		repeat (delay) begin
			@(negedge clk);
			check_bit("io_addr_req", 1'b1, io_addr_req);
			check_bit("cpu_addr_ack_0", 1'b0, cpu_addr_ack_0);
			check_bit("cpu_addr_ack_1", 1'b0, cpu_addr_ack_1);
			next_cycle();
		end
		io_addr_ack = client_vec_t'(1 << (xorshift() % NIOCLIENTS));
		@(negedge clk);
		check_bit("cpu_addr_ack_0", !cpu, cpu_addr_ack_0);
		check_bit("cpu_addr_ack_1", cpu, cpu_addr_ack_1);
		check_addr("io_addr", cpu ? cpu_addr_1 : cpu_addr_0, io_addr);
		next_cycle();
		io_addr_ack = '0;
	endtask

	task automatic return_data(input bit cpu, input xlen_t data, input logic err);
		client_vec_t who;
		who = client_vec_t'(1 << (xorshift() % NIOCLIENTS));
		io_data_req = who;
		io_rdata = data;
		io_data_err = err ? who : '0;
		@(negedge clk);
		check_bit("cpu_data_req_0", !cpu, cpu_data_req_0);
		check_bit("cpu_data_req_1", cpu, cpu_data_req_1);
		check_data("cpu_rdata", data, cpu ? cpu_rdata_1 : cpu_rdata_0);
		check_bit("cpu_data_err", err, cpu ? cpu_data_err_1 : cpu_data_err_0);
		check_bit("io_data_ack", 1'b0, io_data_ack);	// owner holds off one cycle
		next_cycle();
	endtask

	task automatic take_data(input bit cpu);
		if (cpu)
			cpu_data_ack_1 = 1'b1;
		else
			cpu_data_ack_0 = 1'b1;
		@(negedge clk);
		check_bit("io_data_ack", 1'b1, io_data_ack);
		next_cycle();
		{cpu_data_ack_0, cpu_data_ack_1, io_data_req, io_data_err} = '0;
		@(negedge clk);
		check_bit("cpu_data_req_0", 1'b0, cpu_data_req_0);
		check_bit("cpu_data_req_1", 1'b0, cpu_data_req_1);
	endtask

	`include "io_switch_tests.svh"

	initial begin
		errors = 0;
		rng_state = 32'h1d8c;
		rst_n = 1'b0;
		idle_inputs();
		forward_write();
		read_return();
		alternate_grants();
		lock_blocks_other();
		unanswered_address();
		missing_read_data();
		next_cycle();
		$display("check errors: %0d  assertion failures: %0d",
			errors, io_switch_i.chk_i.fails);
		if (errors == 0 && io_switch_i.chk_i.fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+bench
hdl/io_switch_pkg.sv
hdl/io_arbiter.sv
hdl/io_bus_watchdog.sv
hdl/io_switch.sv
bench/io_switch_chk.sv
bench/io_switch_tb.sv

// ==== Bender.yml ====
package:
  name: io_switch

sources:
  - hdl/io_switch_pkg.sv
  - hdl/io_arbiter.sv
  - hdl/io_bus_watchdog.sv
  - hdl/io_switch.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/io_switch_chk.sv
      - bench/io_switch_tb.sv
